//--- filelist.f
+incdir+common
common/cfg_pkg.sv
hdl/cfg_bus_port.sv
cfg_regs/cfg_regs.sv
irq/irq_msg_gen.sv
hdl/bar_match.sv
hdl/cfg_top.sv
bench/tb_cfg_top.sv

//--- Bender.yml
package:
  name: cfg_space

sources:
  - include_dirs:
      - common
    files:
      - common/cfg_pkg.sv
      - hdl/cfg_bus_port.sv
      - cfg_regs/cfg_regs.sv
      - irq/irq_msg_gen.sv
      - hdl/bar_match.sv
      - hdl/cfg_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/tb_cfg_top.sv

//--- bench/tb_cfg_top.sv
`default_nettype none

`include "cfg_params.svh"

module tb_cfg_top;
	import cfg_pkg::*;

	localparam logic [95:0] name_str = `CFG_DEV_NAME;

	logic       clk_i = 1'b0;
	logic       rst_i, cs_i, cyc_i, we_i;
	cfg_sel_t   sel_i;
	cfg_addr_t  adr_i;
	cfg_word_t  dat_i, dat_o;
	logic       ack_o, cs_bar0_o, cs_bar1_o, cs_bar2_o;
	irq_lines_t irq_i;
	irq_vec_t   irq_chain_i, irq_chain_o;

	// Shadow of the writable registers
	logic [15:0] cmd_sh;
	cfg_word_t   bar_sh [3];
	irq_vec_t    vec_sh [4];

	// Outstanding requests, oldest first
	cfg_word_t exp_dat_q [$];
	int        exp_cyc_q [$];
	bit        exp_chk_q [$];
	irq_vec_t  msg_val_q [$];       // Chain messages seen
	int        msg_cyc_q [$];

	int        cyc_cnt = 0;
	int        err_cnt, test_err, test_num, pass_cnt, fail_cnt;
	int        i, n;
	integer    seed;
	cfg_word_t r;

	cfg_top dut0 (.*);

	always #2 clk_i = ~clk_i;

	always @(posedge clk_i) cyc_cnt <= cyc_cnt + 1;

	// ==============================
	// Reference model
	// ==============================
	function automatic cfg_word_t mask_of(input int k);
		case (k)
			0: return `CFG_BAR0_MASK;
			1: return `CFG_BAR1_MASK;
			default: return `CFG_BAR2_MASK;
		endcase
	endfunction

	// Address agrees with the base on every bit the mask selects
	function automatic logic window_hit(input cfg_addr_t adr, input cfg_word_t base,
		input cfg_word_t mask);
		logic hit;
		hit = 1'b1;
		for (int b = 0; b < 32; b++)
			if (mask[b] && adr[b] != base[b])
				hit = 1'b0;
		return hit;
	endfunction

	function automatic cfg_word_t cfg_expect(input cfg_reg_idx_t idx, input irq_lines_t irq);
		case (idx)
			idx_id:       return {`CFG_DEVICE_ID, `CFG_VENDOR_ID};
			idx_cmd_stat: return {16'h02A0 | {12'h0, |irq, 3'b000}, (cmd_sh & 16'h0547) | 16'h0200};
			idx_class:    return {`CFG_CLASS, `CFG_SUBCLASS, `CFG_PROGIF, `CFG_REVISION_ID};
			idx_hdr:      return {8'h00, `CFG_HEADER_TYPE, 8'h00, `CFG_CACHE_LINE};
			idx_bar0, idx_bar1, idx_bar2:
				return bar_sh[idx - idx_bar0];
			idx_ones0, idx_ones1, idx_ones2:
				return 32'hFFFF_FFFF;
			idx_subsys:   return {`CFG_SUBSYS_ID, `CFG_SUBSYS_VENDOR_ID};
			idx_rom:      return `CFG_ROM_ADDR;
			idx_vec0, idx_vec1, idx_vec2, idx_vec3:
				return {16'h0000, vec_sh[idx - idx_vec0]};
			idx_name0:    return name_str[31:0];
			idx_name1:    return name_str[63:32];
			idx_name2:    return name_str[95:64];
			default:      return 32'h0;           // Holes and unmapped
		endcase
	endfunction

	function automatic void shadow_write(input cfg_reg_idx_t idx, input cfg_sel_t sel,
		input cfg_word_t dat);
		int k;
		k = 0;
		case (idx)
			idx_cmd_stat:
				for (int b = 0; b < 2; b++)
					if (sel[b]) cmd_sh[b*8 +: 8] = dat[b*8 +: 8];
			idx_bar0, idx_bar1, idx_bar2: begin
				k = idx - idx_bar0;
				if (&sel && dat == 32'hFFFF_FFFF)
					bar_sh[k] = mask_of(k);           // Size probe
				else
					for (int b = 0; b < 4; b++)
						if (sel[b]) bar_sh[k][b*8 +: 8] = dat[b*8 +: 8];
			end
			idx_vec0, idx_vec1, idx_vec2, idx_vec3:
				if (&sel) vec_sh[idx - idx_vec0] = dat[15:0];
			default: ;
		endcase
	endfunction

	function automatic cfg_addr_t make_adr(input cfg_reg_idx_t idx);
		return {4'h0, `CFG_BUS, `CFG_DEVICE, `CFG_FUNC, 6'h00, idx, 2'b00};
	endfunction

	function automatic cfg_reg_idx_t pick_idx(input logic [3:0] k);
		case (k % 4'd12)
			0:       return idx_cmd_stat;
			1:       return idx_bar0;
			2:       return idx_bar1;
			3:       return idx_bar2;
			4:       return idx_vec0;
			5:       return idx_vec1;
			6:       return idx_vec2;
			7:       return idx_vec3;
			8:       return idx_id;
			9:       return idx_name1;
			10:      return idx_ones1;
			default: return 6'h3E;                // Unmapped
		endcase
	endfunction

	// ==============================
	// Checks and bus tasks
	// ==============================
	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic issue(input logic cs, input logic we, input cfg_sel_t sel,
		input cfg_addr_t adr, input cfg_word_t dat, input bit acked, input bit chk,
		input cfg_word_t exp);
		@(posedge clk_i);
		#1;
		cs_i  = cs;
		cyc_i = 1'b1;
		we_i  = we;
		sel_i = sel;
		adr_i = adr;
		dat_i = dat;
		if (acked) begin
			exp_dat_q.push_back(exp);
			exp_cyc_q.push_back(cyc_cnt + 3);     // Sampled next edge, ack two later
			exp_chk_q.push_back(chk);
		end
	endtask

	task automatic rd(input cfg_reg_idx_t idx);
		issue(1'b1, 1'b0, 4'hF, make_adr(idx), '0, 1'b1, 1'b1, cfg_expect(idx, irq_i));
	endtask

	task automatic wr(input cfg_reg_idx_t idx, input cfg_sel_t sel, input cfg_word_t dat);
		issue(1'b1, 1'b1, sel, make_adr(idx), dat, 1'b1, 1'b0, '0);
		shadow_write(idx, sel, dat);
	endtask

	task automatic wait_cycles(input int cnt);
		for (int k = 0; k < cnt; k++)
			@(posedge clk_i);
	endtask

	task automatic wait_idle();
		int k;
		k = 0;
		@(posedge clk_i);
		#1;
		cs_i  = 1'b0;
		cyc_i = 1'b0;
		we_i  = 1'b0;
		while (exp_cyc_q.size() != 0 && k < 20) begin
			@(posedge clk_i);
			k++;
		end
		if (exp_cyc_q.size() != 0) begin
			$display("Timed out at %0t waiting for outstanding acks", $time);
			err_cnt++;
		end
		wait_cycles(3);                         // Room for stray acks
	endtask

	task automatic probe_cs(input logic cyc, input cfg_addr_t adr);
		@(posedge clk_i);
		#1;
		cs_i  = 1'b0;
		cyc_i = cyc;
		adr_i = adr;
		@(negedge clk_i);
		compare("cs_bar0_o", cs_bar0_o, cyc && window_hit(adr, bar_sh[0], mask_of(0)));
		compare("cs_bar1_o", cs_bar1_o, cyc && window_hit(adr, bar_sh[1], mask_of(1)));
		compare("cs_bar2_o", cs_bar2_o, cyc && window_hit(adr, bar_sh[2], mask_of(2)));
	endtask

	task automatic irq_pulse(input irq_lines_t lines);
		@(posedge clk_i);
		#1 irq_i = lines;
		@(posedge clk_i);
		#1 irq_i = '0;
	endtask

	task automatic finish_test(input string name);
		test_num++;
		if (err_cnt == test_err) begin
			pass_cnt++;
			$display("Test %0d %s: ok", test_num, name);
		end
		else begin
			fail_cnt++;
			$display("Test %0d %s: fail, %0d errors", test_num, name, err_cnt - test_err);
		end
		test_err = err_cnt;
	endtask

	// ==============================
	// Response compare and chain log
	// ==============================
	always @(negedge clk_i) begin
		if (!rst_i) begin
			if (ack_o) begin
				if (exp_cyc_q.size() == 0) begin
					$display("Unexpected ack at %0t with no request outstanding", $time);
					err_cnt++;
				end
				else begin
					compare("ack_o cycle", cyc_cnt, exp_cyc_q.pop_front());
					if (exp_chk_q.pop_front())
						compare("dat_o", dat_o, exp_dat_q.pop_front());
					else
						void'(exp_dat_q.pop_front());
				end
			end
			else begin
				compare("dat_o idle", dat_o, 32'h0);  // Zero without ack
				if (exp_cyc_q.size() != 0 && exp_cyc_q[0] <= cyc_cnt) begin
					$display("Missing ack at %0t for a request", $time);
					err_cnt++;
					void'(exp_cyc_q.pop_front());
					void'(exp_chk_q.pop_front());
					void'(exp_dat_q.pop_front());
				end
			end
			if (irq_chain_o != '0) begin
				msg_val_q.push_back(irq_chain_o);
				msg_cyc_q.push_back(cyc_cnt);
			end
		end
	end

	// ==============================
	// Stimulus
	// ==============================
	initial begin
		seed = 32'hab86127b;
		{err_cnt, test_err, test_num, pass_cnt, fail_cnt} = '0;
		rst_i       = 1'b1;
		cs_i        = 1'b0;
		cyc_i       = 1'b0;
		we_i        = 1'b0;
		sel_i       = '0;
		adr_i       = '0;
		dat_i       = '0;
		irq_i       = '0;
		irq_chain_i = '0;
		cmd_sh      = `CFG_CMD_RESET;
		bar_sh[0]   = `CFG_BAR0_RESET;
		bar_sh[1]   = `CFG_BAR1_RESET;
		bar_sh[2]   = `CFG_BAR2_RESET;
		for (i = 0; i < 4; i++)
			vec_sh[i] = '0;
		wait_cycles(4);
		#1 rst_i = 1'b0;

		// Whole map back to back, then decode misses
		for (i = 0; i < 64; i++)
			rd(cfg_reg_idx_t'(i));
		issue(1'b1, 1'b0, 4'hF, make_adr(idx_id) | 32'h0000_0100, '0, 1'b1, 1'b1, '0);
		issue(1'b1, 1'b0, 4'hF, make_adr(idx_id) ^ 32'h0002_0000, '0, 1'b0, 1'b0, '0);
		issue(1'b0, 1'b0, 4'hF, make_adr(idx_id), '0, 1'b0, 1'b0, '0);
		wait_idle();
		finish_test("identity reads");

		rd(idx_cmd_stat);
		wr(idx_cmd_stat, 4'b0001, 32'hFFFF_FFFF);
		rd(idx_cmd_stat);
		wr(idx_cmd_stat, 4'b0010, 32'hFFFF_FFFF);
		rd(idx_cmd_stat);
		wr(idx_cmd_stat, 4'b1100, 32'h0000_0000); // Status half not writable
		rd(idx_cmd_stat);
		wr(idx_cmd_stat, 4'b0011, 32'h0000_0000);
		rd(idx_cmd_stat);
		wait_idle();
		#1 irq_i = 4'b0100;
		rd(idx_cmd_stat);
		wait_idle();
		#1 irq_i = '0;
		rd(idx_cmd_stat);
		wait_idle();
		finish_test("command and status");

		wr(idx_bar0, 4'hF, 32'h1234_5678);
		rd(idx_bar0);
		wr(idx_bar1, 4'hF, 32'hFFFF_FFFF);
		rd(idx_bar1);
		wr(idx_bar2, 4'b1000, 32'hAB00_0000);
		rd(idx_bar2);
		wr(idx_bar1, 4'hF, 32'hC001_0000);
		rd(idx_bar1);
		wait_idle();
		for (n = 0; n < 3; n++) begin
			r = $random(seed);
			probe_cs(1'b1, bar_sh[n]);
			probe_cs(1'b1, bar_sh[n] ^ (r & ~mask_of(n)));   // Inside the window
			probe_cs(1'b1, bar_sh[n] ^ (mask_of(n) & -mask_of(n))); // Lowest decoded bit
			probe_cs(1'b1, r);
			probe_cs(1'b0, bar_sh[n]);
		end
		wait_idle();
		finish_test("BARs and chip selects");

		for (i = 0; i < 4; i++)
			wr(cfg_reg_idx_t'(idx_vec0 + i), 4'hF, 32'hDEAD_C100 + i * 32'h11);
		wr(idx_vec2, 4'b0111, 32'h0000_7777);        // Partial write dropped
		for (i = 0; i < 4; i++)
			rd(cfg_reg_idx_t'(idx_vec0 + i));
		wait_idle();
		wait_cycles(70);                            // Holdoff from earlier pulses
		for (n = 0; n < 4; n += 2) begin
			msg_val_q.delete();
			irq_pulse(4'b0001 << n);
			wait_cycles(6);
			compare("message count", msg_val_q.size(), 1);
			if (msg_val_q.size() != 0)
				compare("irq_chain_o", msg_val_q[0], vec_sh[n]);
		end
		msg_val_q.delete();
		irq_pulse(4'b1010);
		wait_cycles(6);
		compare("message count", msg_val_q.size(), 2);
		if (msg_val_q.size() == 2) begin
			compare("irq_chain_o first", msg_val_q[0], vec_sh[1]);
			compare("irq_chain_o second", msg_val_q[1], vec_sh[3]);
		end
		wait_cycles(70);
		msg_val_q.delete();
		@(posedge clk_i);
		#1;
		irq_chain_i = 16'h5A5A;                    // Upstream busy for five cycles
		irq_i       = 4'b0001;
		@(posedge clk_i);
		#1 irq_i = '0;
		wait_cycles(3);
		@(posedge clk_i);
		#1 irq_chain_i = '0;
		wait_cycles(4);
		compare("message count", msg_val_q.size(), 6);
		for (i = 0; i < msg_val_q.size(); i++)
			compare("irq_chain_o", msg_val_q[i], (i == 5) ? vec_sh[0] : 16'h5A5A);
		finish_test("interrupt messages");

		msg_val_q.delete();
		msg_cyc_q.delete();
		@(posedge clk_i);
		#1 irq_i = 4'b0100;
		wait_cycles(200);
		#1 irq_i = '0;
		wait_cycles(5);
		if (msg_val_q.size() < 2) begin
			$display("Held line produced %0d messages, expected repeats", msg_val_q.size());
			err_cnt++;
		end
		for (i = 1; i < msg_cyc_q.size(); i++)
			if (msg_cyc_q[i] - msg_cyc_q[i-1] < 64) begin
				$display("Repeat message only %0d cycles apart", msg_cyc_q[i] - msg_cyc_q[i-1]);
				err_cnt++;
			end
		finish_test("interrupt holdoff");

		for (i = 0; i < 120; i++) begin
			r = $random(seed);
			if (r[4]) begin
				wr(pick_idx(r[3:0]), r[8:5], (r[11:9] == 3'd0) ? 32'hFFFF_FFFF : $random(seed));
			end
			else
				rd(pick_idx(r[3:0]));
		end
		wait_idle();
		finish_test("random traffic");

		$display("Tests passed: %0d, failed: %0d, errors: %0d", pass_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TESTBENCH PASSED");
		end
		else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/cfg_top.sv
`default_nettype none

module cfg_top (
	input  wire logic                clk_i,
	input  wire logic                rst_i,
	// Config bus
	input  wire logic                cs_i,
	input  wire logic                cyc_i,
	input  wire logic                we_i,
	input  wire cfg_pkg::cfg_sel_t   sel_i,
	input  wire cfg_pkg::cfg_addr_t  adr_i,
	input  wire cfg_pkg::cfg_word_t  dat_i,
	output cfg_pkg::cfg_word_t       dat_o,
	output logic                     ack_o,
	// Window selects
	output logic                     cs_bar0_o,
	output logic                     cs_bar1_o,
	output logic                     cs_bar2_o,
	// Interrupts
	input  wire cfg_pkg::irq_lines_t irq_i,
	input  wire cfg_pkg::irq_vec_t   irq_chain_i,
	output cfg_pkg::irq_vec_t        irq_chain_o
);
	import cfg_pkg::*;

	// Captured request
	logic         req_valid;
	logic         req_we;
	cfg_sel_t     req_sel;
	cfg_reg_idx_t req_idx;
	cfg_word_t    req_dat;
	cfg_word_t    rd_dat;          // Registered read mux

	// Register contents to the side blocks
	cfg_word_t bar0, bar1, bar2;
	irq_vec_t  irq_vec0, irq_vec1, irq_vec2, irq_vec3;

	cfg_bus_port u_bus_port (
		.clk_i(clk_i), .rst_i(rst_i),
		.cs_i(cs_i), .cyc_i(cyc_i), .we_i(we_i),
		.sel_i(sel_i), .adr_i(adr_i), .dat_i(dat_i),
		.rd_dat_i(rd_dat),
		.req_valid_o(req_valid), .req_we_o(req_we), .req_sel_o(req_sel),
		.req_idx_o(req_idx), .req_dat_o(req_dat),
		.ack_o(ack_o), .dat_o(dat_o)
	);

	cfg_regs u_regs (
		.clk_i(clk_i), .rst_i(rst_i),
		.req_valid_i(req_valid), .req_we_i(req_we), .req_sel_i(req_sel),
		.req_idx_i(req_idx), .req_dat_i(req_dat),
		.irq_i(irq_i),
		.rd_dat_o(rd_dat),
		.bar0_o(bar0), .bar1_o(bar1), .bar2_o(bar2),
		.irq_vec0_o(irq_vec0), .irq_vec1_o(irq_vec1),
		.irq_vec2_o(irq_vec2), .irq_vec3_o(irq_vec3)
	);

	bar_match u_bar_match (
		.cyc_i(cyc_i), .adr_i(adr_i),
		.bar0_i(bar0), .bar1_i(bar1), .bar2_i(bar2),
		.cs_bar0_o(cs_bar0_o), .cs_bar1_o(cs_bar1_o), .cs_bar2_o(cs_bar2_o)
	);

	irq_msg_gen u_irq_msg_gen (
		.clk_i(clk_i), .rst_i(rst_i),
		.irq_i(irq_i),
		.irq_vec0_i(irq_vec0), .irq_vec1_i(irq_vec1),
		.irq_vec2_i(irq_vec2), .irq_vec3_i(irq_vec3),
		.irq_chain_i(irq_chain_i),
		.irq_chain_o(irq_chain_o)
	);

endmodule

`default_nettype wire

//--- hdl/bar_match.sv
`default_nettype none

`include "cfg_params.svh"

module bar_match (
	input  wire logic               cyc_i,
	input  wire cfg_pkg::cfg_addr_t adr_i,
	input  wire cfg_pkg::cfg_word_t bar0_i,
	input  wire cfg_pkg::cfg_word_t bar1_i,
	input  wire cfg_pkg::cfg_word_t bar2_i,
	output logic                    cs_bar0_o,
	output logic                    cs_bar1_o,
	output logic                    cs_bar2_o
);

	// ==============================
	// Masked window compares
	// ==============================
	// Only bits set in the mask must agree with the BAR
	// Low bits below the window size are don't-care

	assign cs_bar0_o = cyc_i && (((adr_i ^ bar0_i) & `CFG_BAR0_MASK) == 32'd0);

	assign cs_bar1_o = cyc_i && (((adr_i ^ bar1_i) & `CFG_BAR1_MASK) == 32'd0);

	assign cs_bar2_o = cyc_i && (((adr_i ^ bar2_i) & `CFG_BAR2_MASK) == 32'd0);

endmodule

`default_nettype wire

//--- irq/irq_msg_gen.sv
`default_nettype none

`include "cfg_params.svh"

module irq_msg_gen (
	input  wire logic                clk_i,
	input  wire logic                rst_i,
	input  wire cfg_pkg::irq_lines_t irq_i,
	input  wire cfg_pkg::irq_vec_t   irq_vec0_i,
	input  wire cfg_pkg::irq_vec_t   irq_vec1_i,
	input  wire cfg_pkg::irq_vec_t   irq_vec2_i,
	input  wire cfg_pkg::irq_vec_t   irq_vec3_i,
	input  wire cfg_pkg::irq_vec_t   irq_chain_i,  // Upstream messages
	output cfg_pkg::irq_vec_t        irq_chain_o   // Downstream messages
);
	import cfg_pkg::*;

	irq_vec_t   vec [4];
	irq_lines_t pend_q;            // Message waiting for a free slot
	irq_timer_t timer_q [4];       // Holdoff per line
	logic       win_vld;
	logic [1:0] win_idx;           // Lowest pending line
	logic       insert;

	assign vec[0] = irq_vec0_i;
	assign vec[1] = irq_vec1_i;
	assign vec[2] = irq_vec2_i;
	assign vec[3] = irq_vec3_i;

	// Scan down so the lowest pending line is left standing
	always_comb begin
		win_vld = 1'b0;
		win_idx = 2'd0;
		for (int i = 3; i >= 0; i--) begin
			if (pend_q[i]) begin
				win_vld = 1'b1;
				win_idx = i[1:0];
			end
		end
	end

	// Chain slot is free only when upstream sends nothing
	assign insert = win_vld && (irq_chain_i == '0);

	// ==============================
	// Pending flags, timers, chain
	// ==============================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pend_q      <= '0;
			irq_chain_o <= '0;
			for (int i = 0; i < 4; i++)
				timer_q[i] <= `IRQ_HOLDOFF_MAX; // Ready to fire
		end
		else begin
			irq_chain_o <= irq_chain_i;           // Default pass-through
			for (int i = 0; i < 4; i++) begin
				if (timer_q[i] != `IRQ_HOLDOFF_MAX)
					timer_q[i] <= timer_q[i] + irq_timer_t'(1); // Saturating count
				if (irq_i[i] && timer_q[i] == `IRQ_HOLDOFF_MAX)
					pend_q[i] <= 1'b1;
			end
			// Winner overrides pass-through and restarts its holdoff
			if (insert) begin
				irq_chain_o      <= vec[win_idx];
				pend_q[win_idx]  <= 1'b0;
				timer_q[win_idx] <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- cfg_regs/cfg_regs.sv
`default_nettype none

`include "cfg_params.svh"

module cfg_regs (
	input  wire logic                  clk_i,
	input  wire logic                  rst_i,
	input  wire logic                  req_valid_i,
	input  wire logic                  req_we_i,
	input  wire cfg_pkg::cfg_sel_t     req_sel_i,
	input  wire cfg_pkg::cfg_reg_idx_t req_idx_i,
	input  wire cfg_pkg::cfg_word_t    req_dat_i,
	input  wire cfg_pkg::irq_lines_t   irq_i,
	output cfg_pkg::cfg_word_t         rd_dat_o,
	output cfg_pkg::cfg_word_t         bar0_o,
	output cfg_pkg::cfg_word_t         bar1_o,
	output cfg_pkg::cfg_word_t         bar2_o,
	output cfg_pkg::irq_vec_t          irq_vec0_o,
	output cfg_pkg::irq_vec_t          irq_vec1_o,
	output cfg_pkg::irq_vec_t          irq_vec2_o,
	output cfg_pkg::irq_vec_t          irq_vec3_o
);
	import cfg_pkg::*;

	localparam logic [95:0] dev_name   = `CFG_DEV_NAME;
	localparam logic [15:0] stat_fixed = 16'h02A0;  // 66 MHz, fast b2b, medium DEVSEL

	logic [15:0] cmd_q;            // Command register as written
	logic [15:0] cmd_rd;           // With forced bits applied
	logic [15:0] stat_rd;
	irq_vec_t    vec_q [4];
	logic        wr_en;

	// All-ones full write returns the size mask, else byte merge
	function automatic cfg_word_t fn_bar_wr(input cfg_word_t cur, input cfg_word_t mask,
		input cfg_sel_t sel, input cfg_word_t dat);
		cfg_word_t nxt;
		nxt = cur;
		if (&sel && dat == '1)
			nxt = mask;                 // Sizing probe
		else
			for (int b = 0; b < 4; b++)
				if (sel[b])
					nxt[b*8 +: 8] = dat[b*8 +: 8];
		return nxt;
	endfunction

	assign wr_en = req_valid_i && req_we_i;

	// ==============================
	// Command and status
	// ==============================
	always_comb begin
		cmd_rd        = cmd_q;
		cmd_rd[3]     = 1'b0;         // No special cycles
		cmd_rd[4]     = 1'b0;         // No write-and-invalidate
		cmd_rd[5]     = 1'b0;         // No palette snoop
		cmd_rd[7]     = 1'b0;         // Reserved
		cmd_rd[9]     = 1'b1;         // Fast back-to-back always on
		cmd_rd[15:11] = 5'd0;         // Reserved
	end

	always_comb begin
		stat_rd    = stat_fixed;
		stat_rd[3] = |irq_i;          // Interrupt status
	end

	// ==============================
	// Register writes
	// ==============================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cmd_q  <= `CFG_CMD_RESET;
			bar0_o <= `CFG_BAR0_RESET;
			bar1_o <= `CFG_BAR1_RESET;
			bar2_o <= `CFG_BAR2_RESET;
			for (int i = 0; i < 4; i++)
				vec_q[i] <= '0;
		end
		else if (wr_en) begin
			case (req_idx_i)
				idx_cmd_stat: begin
					if (req_sel_i[0]) cmd_q[7:0]  <= req_dat_i[7:0];
					if (req_sel_i[1]) cmd_q[15:8] <= req_dat_i[15:8];
				end
				idx_bar0: bar0_o <= fn_bar_wr(bar0_o, `CFG_BAR0_MASK, req_sel_i, req_dat_i);
				idx_bar1: bar1_o <= fn_bar_wr(bar1_o, `CFG_BAR1_MASK, req_sel_i, req_dat_i);
				idx_bar2: bar2_o <= fn_bar_wr(bar2_o, `CFG_BAR2_MASK, req_sel_i, req_dat_i);
				idx_vec0, idx_vec1, idx_vec2, idx_vec3:
					if (&req_sel_i)           // Full word writes only
						vec_q[req_idx_i[1:0]] <= req_dat_i[15:0];
				default: ;                  // Read-only or unmapped
			endcase
		end
	end

	assign irq_vec0_o = vec_q[0];
	assign irq_vec1_o = vec_q[1];
	assign irq_vec2_o = vec_q[2];
	assign irq_vec3_o = vec_q[3];

	// ==============================
	// Read mux, one register stage
	// ==============================
	always_ff @(posedge clk_i) begin
		case (req_idx_i)
			idx_id:       rd_dat_o <= {`CFG_DEVICE_ID, `CFG_VENDOR_ID};
			idx_cmd_stat: rd_dat_o <= {stat_rd, cmd_rd};
			idx_class:    rd_dat_o <= {`CFG_CLASS, `CFG_SUBCLASS, `CFG_PROGIF, `CFG_REVISION_ID};
			idx_hdr:      rd_dat_o <= {8'h00, `CFG_HEADER_TYPE, 8'h00, `CFG_CACHE_LINE};
			idx_bar0:     rd_dat_o <= bar0_o;
			idx_bar1:     rd_dat_o <= bar1_o;
			idx_bar2:     rd_dat_o <= bar2_o;
			idx_ones0, idx_ones1, idx_ones2:
				rd_dat_o <= '1;             // BARs not implemented
			idx_zero0, idx_zero1:
				rd_dat_o <= '0;
			idx_subsys:   rd_dat_o <= {`CFG_SUBSYS_ID, `CFG_SUBSYS_VENDOR_ID};
			idx_rom:      rd_dat_o <= `CFG_ROM_ADDR;
			idx_vec0:     rd_dat_o <= {16'h0000, vec_q[0]};
			idx_vec1:     rd_dat_o <= {16'h0000, vec_q[1]};
			idx_vec2:     rd_dat_o <= {16'h0000, vec_q[2]};
			idx_vec3:     rd_dat_o <= {16'h0000, vec_q[3]};
			idx_name0:    rd_dat_o <= dev_name[31:0];
			idx_name1:    rd_dat_o <= dev_name[63:32];
			idx_name2:    rd_dat_o <= dev_name[95:64];
			default:      rd_dat_o <= '0;  // Holes and out-of-range read zero
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/cfg_bus_port.sv
`default_nettype none

`include "cfg_params.svh"

module cfg_bus_port (
	input  wire logic               clk_i,
	input  wire logic               rst_i,
	input  wire logic               cs_i,
	input  wire logic               cyc_i,
	input  wire logic               we_i,
	input  wire cfg_pkg::cfg_sel_t  sel_i,
	input  wire cfg_pkg::cfg_addr_t adr_i,
	input  wire cfg_pkg::cfg_word_t dat_i,
	input  wire cfg_pkg::cfg_word_t rd_dat_i,     // From register read mux
	output logic                    req_valid_o,
	output logic                    req_we_o,
	output cfg_pkg::cfg_sel_t       req_sel_o,
	output cfg_pkg::cfg_reg_idx_t   req_idx_o,
	output cfg_pkg::cfg_word_t      req_dat_o,
	output logic                    ack_o,
	output cfg_pkg::cfg_word_t      dat_o
);
	import cfg_pkg::*;

	logic         cfg_hit;         // This function is addressed
	logic         hi_zero;         // Address lies in the mapped page
	cfg_reg_idx_t idx_next;
	logic         rd_vld;          // Read mux output now valid

	// ==============================
	// Address decode
	// ==============================
	assign cfg_hit = cs_i && cyc_i &&
		adr_i[`CFG_BUS_BITS] == `CFG_BUS &&
		adr_i[`CFG_DEVICE_BITS] == `CFG_DEVICE &&
		adr_i[`CFG_FUNC_BITS] == `CFG_FUNC;

	assign hi_zero = adr_i[`CFG_HI_BITS] == '0;

	// Upper page bits push the access outside the map
	assign idx_next = hi_zero ? cfg_reg_idx_t'(adr_i[`CFG_IDX_BITS]) : idx_none;

	// ==============================
	// Request capture
	// ==============================
	always_ff @(posedge clk_i) begin
		req_we_o  <= we_i;            // Payload, no reset
		req_sel_o <= sel_i;
		req_idx_o <= idx_next;
		req_dat_o <= dat_i;
	end

	// ==============================
	// Valid pipeline and response
	// ==============================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			req_valid_o <= 1'b0;
			rd_vld      <= 1'b0;
			ack_o       <= 1'b0;
			dat_o       <= '0;
		end
		else begin
			req_valid_o <= cfg_hit;     // Stage 0, write lands on next edge
			rd_vld      <= req_valid_o; // Stage 1, read mux has sampled
			ack_o       <= rd_vld;      // Stage 2
			// Data bus stays low outside an ack cycle
			dat_o <= rd_vld ? rd_dat_i : '0;
		end
	end

endmodule

`default_nettype wire

//--- common/cfg_pkg.sv
`default_nettype none

package cfg_pkg;

	// Bus side widths
	typedef logic [31:0] cfg_word_t;       // Data word
	typedef logic [31:0] cfg_addr_t;       // Byte address
	typedef logic [3:0]  cfg_sel_t;        // Byte selects
	typedef logic [5:0]  cfg_reg_idx_t;    // Word index in register map

	// Interrupt side widths
	typedef logic [15:0] irq_vec_t;        // Message vector, also chain bus
	typedef logic [3:0]  irq_lines_t;      // One bit per line
	typedef logic [5:0]  irq_timer_t;      // Holdoff count

	// Register map word indexes
	typedef enum logic [5:0] {
		idx_id       = 6'h00,                // Device / vendor
		idx_cmd_stat = 6'h01,                // Status / command
		idx_class    = 6'h02,
		idx_hdr      = 6'h03,                // Header type, cache line
		idx_bar0     = 6'h04,
		idx_bar1     = 6'h05,
		idx_bar2     = 6'h06,
		idx_ones0    = 6'h07,                // Unimplemented BARs
		idx_ones1    = 6'h08,
		idx_ones2    = 6'h09,
		idx_zero0    = 6'h0A,
		idx_subsys   = 6'h0B,
		idx_rom      = 6'h0C,
		idx_zero1    = 6'h0D,
		idx_vec0     = 6'h10,                // Interrupt vectors
		idx_vec1     = 6'h11,
		idx_vec2     = 6'h12,
		idx_vec3     = 6'h13,
		idx_name0    = 6'h20,                // Device name, low word first
		idx_name1    = 6'h21,
		idx_name2    = 6'h22,
		idx_none     = 6'h3F                 // Outside the map
	} cfg_reg_e;

endpackage

`default_nettype wire

//--- common/cfg_params.svh
`ifndef CFG_PARAMS_SVH
`define CFG_PARAMS_SVH

// ==============================
// Address decode fields
// ==============================
`define CFG_BUS             6'd0           // Bus number match
`define CFG_DEVICE          5'd3           // Device number match
`define CFG_FUNC            3'd0           // Function number match
`define CFG_BUS_BITS        27:22          // Bus field position
`define CFG_DEVICE_BITS     21:17          // Device field position
`define CFG_FUNC_BITS       16:14          // Function field position
`define CFG_HI_BITS         13:8           // Must be zero for a mapped register
`define CFG_IDX_BITS        7:2            // Word index in register map

// ==============================
// Identity words
// ==============================
`define CFG_VENDOR_ID        16'h1A2B
`define CFG_DEVICE_ID        16'h0C41
`define CFG_SUBSYS_VENDOR_ID 16'h1A2B
`define CFG_SUBSYS_ID        16'h0001
`define CFG_CLASS            8'h03         // Display controller
`define CFG_SUBCLASS         8'h80         // Other
`define CFG_PROGIF           8'h01
`define CFG_REVISION_ID      8'h00
`define CFG_CACHE_LINE       8'h08         // In 32-bit units
`define CFG_HEADER_TYPE      8'h00         // General device
`define CFG_ROM_ADDR         32'hFFFF_FFF0
`define CFG_DEV_NAME         "CFG DEVICE  "

// ==============================
// Reset values and BAR masks
// ==============================
`define CFG_CMD_RESET        16'h4003
`define CFG_BAR0_RESET       32'hFEC0_0000
`define CFG_BAR1_RESET       32'hFED0_0000
`define CFG_BAR2_RESET       32'hFEE0_0000
`define CFG_BAR0_MASK        32'hFFF0_0000 // 1 MB window
`define CFG_BAR1_MASK        32'hFFFF_0000 // 64 kB window
`define CFG_BAR2_MASK        32'hFFFF_F000 // 4 kB window

// Holdoff timer ceiling, also the idle value
`define IRQ_HOLDOFF_MAX      6'd63

`endif
